//--- all.f
verilog/upPkg.sv
verilog/upMemory.sv
verilog/upApbPort.sv
verilog/upDecode.sv
verilog/upExecute.sv
verilog/upResult.sv
verilog/upCore.sv
testbench/tbClock.sv
testbench/tbUpCore.sv

//--- testbench/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic nRst
);

	localparam int halfPeriod = 4; // 8 ns clock
	localparam int rstCycles  = 16;

	initial begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	initial begin
		nRst = 1'b0;
		repeat (rstCycles) @(posedge clk);
		@(negedge clk);
		nRst = 1'b1; // released away from the active edge
	end

endmodule

//--- testbench/tbUpCore.sv
`timescale 1ns/1ps

module tbUpCore;

	import upPkg::*;

	localparam int maxEntries = 1024;
	localparam int randCount  = 300;
	localparam int settleNs   = 2;
	localparam int kWrite     = 0;
	localparam int kRead      = 1;
	localparam int kBad       = 2;

	logic                  clk;
	logic                  nRst;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [3:0]            paddr;
	logic [instrWidth-1:0] pwdata;
	logic [instrWidth-1:0] prdata;
	logic                  pready;
	logic                  pslverr;

	// stimulus table
	int                    numEntries;
	string                 names [maxEntries];
	int                    kinds [maxEntries];
	logic [3:0]            offsets [maxEntries];
	logic                  writes [maxEntries];
	logic [instrWidth-1:0] wdatas [maxEntries];
	logic [instrWidth-1:0] expReads [maxEntries];
	logic                  expErrs [maxEntries];

	// reference model state
	logic [dataWidth-1:0]  mAcc;
	logic                  mZero;
	logic                  mCarry;
	logic [dataWidth-1:0]  mMem [256];

	int byteErrs;
	int flagErrs;
	int errErrs;
	int readyErrs;
	int cycles;
	int cycleLimit;

	tbClock uClock (.clk(clk), .nRst(nRst));

	upCore u_dut (
		.clk(clk), .nRst(nRst),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	function automatic instrT makeInstr(input logic [3:0] op, input logic [7:0] low);
		instrT w;
		w = '0;
		w.immView.opcode = opcodeT'(op);
		w.immView.imm    = low;
		return w;
	endfunction

	task automatic modelStep(input logic [3:0] op, input logic [7:0] low);
		int                   total;
		logic [dataWidth-1:0] b;
		logic                 accWritten;
		accWritten = 1'b1;
		b = (op == opAddi || op == opLdi) ? low : mMem[low];
		case (op)
			opLdi, opLd: begin
				mAcc = b; // carry kept
			end
			opSt: begin
				mMem[low] = mAcc;
				accWritten = 1'b0;
			end
			opAdd, opAddi: begin
				total  = int'(mAcc) + int'(b);
				mCarry = (total > 255); // unsigned overflow
				mAcc   = 8'(total);
			end
			opSub: begin
				mCarry = (mAcc < b); // borrow
				mAcc   = mAcc - b;
			end
			opAnd: begin
				mAcc   = mAcc & b;
				mCarry = 1'b0;
			end
			opOr: begin
				mAcc   = mAcc | b;
				mCarry = 1'b0;
			end
			opXor: begin
				mAcc   = mAcc ^ b;
				mCarry = 1'b0;
			end
			default: accWritten = 1'b0; // nop and illegal codes
		endcase
		if (accWritten) begin
			mZero = (mAcc == '0);
		end
	endtask

	task automatic addEntry(input string name, input int kind, input logic [3:0] offset,
		input logic wr, input logic [instrWidth-1:0] data, input logic [instrWidth-1:0] expRd,
		input logic expErr);
		names[numEntries]    = name;
		kinds[numEntries]    = kind;
		offsets[numEntries]  = offset;
		writes[numEntries]   = wr;
		wdatas[numEntries]   = data;
		expReads[numEntries] = expRd;
		expErrs[numEntries]  = expErr;
		numEntries++;
	endtask

	task automatic addInstr(input string name, input logic [3:0] op, input logic [7:0] low);
		addEntry(name, kWrite, regInstr, 1'b1, makeInstr(op, low), '0, 1'b0);
		modelStep(op, low);
	endtask

	task automatic addReadAcc(input string name);
		addEntry(name, kRead, regAcc, 1'b0, '0, {8'h00, mAcc}, 1'b0);
	endtask

	task automatic addReadFlags(input string name);
		logic [instrWidth-1:0] w;
		w = '0;
		w[flagZero]  = mZero;
		w[flagCarry] = mCarry;
		addEntry(name, kRead, regFlags, 1'b0, '0, w, 1'b0);
	endtask

	task automatic addBad(input string name, input logic [3:0] offset, input logic wr);
		addEntry(name, kBad, offset, wr, 16'h90a5, '0, 1'b1); // addi a5 if it leaked through
	endtask

	task automatic buildDirected();
		addReadAcc("reset acc");
		addReadFlags("reset flags");
		addInstr("ld cleared 00", opLd, 8'h00);
		addReadAcc("ld cleared 00");
		addInstr("ld cleared ff", opLd, 8'hff);
		addReadAcc("ld cleared ff");
		addInstr("ld cleared 5a", opLd, 8'h5a);
		addReadAcc("ld cleared 5a");
		addReadFlags("ld cleared flags");
		// store and load back
		addInstr("ldi 3c", opLdi, 8'h3c);
		addInstr("st 10", opSt, 8'h10);
		addInstr("ldi 00", opLdi, 8'h00);
		addReadFlags("ldi zero");
		addInstr("ld 10", opLd, 8'h10);
		addReadAcc("ld 10");
		addReadFlags("ld 10 flags");
		addInstr("ldi 80", opLdi, 8'h80);
		addInstr("addi wrap", opAddi, 8'h80);
		addInstr("st keeps flags", opSt, 8'h11);
		addReadFlags("st keeps flags");
		// add and sub with carry and borrow
		addInstr("ldi f0", opLdi, 8'hf0);
		addInstr("st 21", opSt, 8'h21);
		addInstr("ldi 20", opLdi, 8'h20);
		addInstr("add carry", opAdd, 8'h21);
		addReadAcc("add carry");
		addReadFlags("add carry");
		addInstr("sub borrow", opSub, 8'h21);
		addReadAcc("sub borrow");
		addReadFlags("sub borrow");
		addInstr("ldi f0 again", opLdi, 8'hf0);
		addInstr("sub to zero", opSub, 8'h21);
		addReadAcc("sub to zero");
		addReadFlags("sub to zero");
		addInstr("addi 01", opAddi, 8'h01);
		addInstr("addi ff wrap", opAddi, 8'hff);
		addReadAcc("addi ff wrap");
		addReadFlags("addi ff wrap");
		// logic ops, ldi and ld keep carry
		addInstr("ldi 0f", opLdi, 8'h0f);
		addInstr("st 30", opSt, 8'h30);
		addInstr("ldi ff", opLdi, 8'hff);
		addInstr("st 31", opSt, 8'h31);
		addInstr("addi set carry", opAddi, 8'h02);
		addInstr("ldi keeps carry", opLdi, 8'hf0);
		addReadFlags("ldi keeps carry");
		addInstr("and to zero", opAnd, 8'h30);
		addReadAcc("and to zero");
		addReadFlags("and to zero");
		addInstr("or 30", opOr, 8'h30);
		addInstr("xor 31", opXor, 8'h31);
		addReadAcc("xor 31");
		addReadFlags("xor 31");
		addInstr("st 32", opSt, 8'h32);
		addInstr("xor self", opXor, 8'h32);
		addReadFlags("xor self");
		addInstr("ldi 80 carry", opLdi, 8'h80);
		addInstr("addi 80 carry", opAddi, 8'h80);
		addInstr("ld keeps carry", opLd, 8'h30);
		addReadAcc("ld keeps carry");
		addReadFlags("ld keeps carry");
		// nop, illegal codes and bad accesses
		addInstr("ldi 55", opLdi, 8'h55);
		addInstr("addi c0", opAddi, 8'hc0);
		addInstr("nop", opNop, 8'h12);
		addInstr("illegal a", 4'ha, 8'h10);
		addInstr("illegal f", 4'hf, 8'h00);
		addReadAcc("after illegal");
		addReadFlags("after illegal");
		addBad("write acc", regAcc, 1'b1);
		addBad("write flags", regFlags, 1'b1);
		addBad("read hole 2", 4'h2, 1'b0);
		addBad("write hole c", 4'hc, 1'b1);
		addBad("read hole f", 4'hf, 1'b0);
		addReadAcc("after bad access");
		addReadFlags("after bad access");
	endtask

	task automatic buildRandom();
		logic [3:0] op;
		logic [7:0] low;
		for (int k = 0; k < randCount; k++) begin
			op  = $urandom % 16; // includes nop and illegal codes
			low = ($urandom % 2) ? 8'($urandom) : 8'($urandom % 16); // reuse a few addresses
			addInstr($sformatf("random %0d", k), op, low);
			addReadAcc($sformatf("random %0d acc", k));
			addReadFlags($sformatf("random %0d flags", k));
		end
	endtask

	task automatic checkByte(input string name, input logic [dataWidth-1:0] exp,
		input logic [dataWidth-1:0] act);
		if (act !== exp) begin
			$display("error %s: expected %02h, actual %02h", name, exp, act);
			byteErrs++;
		end
	endtask

	task automatic checkFlags(input string name, input logic expZ, input logic expC,
		input logic actZ, input logic actC);
		if (actZ !== expZ || actC !== expC) begin
			$display("error %s: expected z=%b c=%b, actual z=%b c=%b", name, expZ, expC,
				actZ, actC);
			flagErrs++;
		end
	endtask

	task automatic checkErr(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("error %s: expected pslverr %b, actual %b", name, exp, act);
			errErrs++;
		end
	endtask

	task automatic checkReady(input string name, input logic act);
		if (act !== 1'b1) begin
			$display("error %s: expected pready 1, actual %b", name, act);
			readyErrs++;
		end
	endtask

	task automatic apbAccess(input logic wr, input logic [3:0] addr,
		input logic [instrWidth-1:0] data, output logic [instrWidth-1:0] rd, output logic err,
		output logic rdy);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk);
		penable = 1'b1; // access phase, no wait states
		#(settleNs);
		rdy = pready;
		rd  = prdata;
		err = pslverr;
		@(posedge clk); // transfer completes here
	endtask

	task automatic runEntry(input int i);
		logic [instrWidth-1:0] rd;
		logic                  err;
		logic                  rdy;
		apbAccess(writes[i], offsets[i], wdatas[i], rd, err, rdy);
		checkReady(names[i], rdy);
		checkErr(names[i], expErrs[i], err);
		if (kinds[i] == kRead && offsets[i] == regAcc) begin
			checkByte(names[i], expReads[i][dataWidth-1:0], rd[dataWidth-1:0]);
		end else if (kinds[i] == kRead && offsets[i] == regFlags) begin
			checkFlags(names[i], expReads[i][flagZero], expReads[i][flagCarry],
				rd[flagZero], rd[flagCarry]);
		end
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycleLimit > 0 && cycles > cycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		numEntries = 0;
		byteErrs   = 0;
		flagErrs   = 0;
		errErrs    = 0;
		readyErrs  = 0;
		cycles     = 0;
		cycleLimit = 0;
		mAcc       = '0;
		mZero      = 1'b0;
		mCarry     = 1'b0;
		for (int a = 0; a < 256; a++) begin
			mMem[a] = '0; // memory comes out of reset cleared
		end
		void'($urandom(99121));
		buildDirected();
		buildRandom();
		cycleLimit = 16 + 4 * numEntries + 50;
		wait (nRst === 1'b1);
		for (int i = 0; i < numEntries; i++) begin
			runEntry(i);
		end
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		repeat (2) @(posedge clk);
		$display("errors: value %0d, flags %0d, pslverr %0d, pready %0d", byteErrs, flagErrs,
			errErrs, readyErrs);
		if (byteErrs + flagErrs + errErrs + readyErrs == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- verilog/upApbPort.sv
`timescale 1ns/1ps

module upApbPort (
	input  logic                         clk,
	input  logic                         nRst,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [3:0]                   paddr,
	input  logic [upPkg::instrWidth-1:0] pwdata,
	output logic [upPkg::instrWidth-1:0] prdata,
	output logic                         pready,
	output logic                         pslverr,
	output logic                         issue,
	output upPkg::instrT                 issueWord,
	input  logic [upPkg::dataWidth-1:0]  acc,
	input  logic                         zero,
	input  logic                         carry
);

	import upPkg::*;

	logic access;
	logic knownReg;
	logic badWrite;

	assign access = psel && penable; // access phase
	assign pready = 1'b1; // core never stalls

	always_comb begin
		knownReg = 1'b0;
		case (paddr)
			regInstr, regAcc, regFlags: knownReg = 1'b1;
			default:                    knownReg = 1'b0;
		endcase
	end

	assign badWrite = pwrite && (paddr != regInstr); // acc and flags are read only
	assign pslverr = access && (!knownReg || badWrite);

	// one cycle wide, sampled by decode on the completing edge
	assign issue = access && pready && pwrite && (paddr == regInstr);
	assign issueWord = pwdata;

	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			case (paddr)
				regAcc: begin
					prdata[dataWidth-1:0] = acc;
				end
				regFlags: begin
					prdata[flagZero]  = zero;
					prdata[flagCarry] = carry;
				end
				default: begin
					prdata = '0; // instr register and holes read as zero
				end
			endcase
		end
	end

	// host must hold psel through setup into the access phase
	apbSetupFirst: assert property (@(posedge clk) disable iff (!nRst)
		penable |-> psel && $past(psel));

endmodule

//--- verilog/upCore.sv
`timescale 1ns/1ps

module upCore (
	input  logic                         clk,
	input  logic                         nRst,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [3:0]                   paddr,
	input  logic [upPkg::instrWidth-1:0] pwdata,
	output logic [upPkg::instrWidth-1:0] prdata,
	output logic                         pready,
	output logic                         pslverr
);

	import upPkg::*;

	logic                 issue;
	instrT                issueWord;
	logic                 opValid;
	opcodeT               opcode;
	logic [dataWidth-1:0] operand;
	logic [addrWidth-1:0] memAddr;
	logic                 useMem;
	logic                 writesAcc;
	logic                 writesMem;
	logic [dataWidth-1:0] rdData;
	logic                 commit;
	logic [dataWidth-1:0] nextAcc;
	logic                 nextZero;
	logic                 nextCarry;
	logic                 storeEn;
	logic [dataWidth-1:0] storeData;
	logic [dataWidth-1:0] acc;
	logic                 zero;
	logic                 carry;
	logic                 memWe;
	logic [dataWidth-1:0] memWrData;

	upApbPort uApbPort (
		.clk(clk), .nRst(nRst),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.issue(issue), .issueWord(issueWord),
		.acc(acc), .zero(zero), .carry(carry)
	);

	upDecode uDecode (
		.clk(clk), .nRst(nRst),
		.issue(issue), .issueWord(issueWord),
		.opValid(opValid), .opcode(opcode), .operand(operand), .memAddr(memAddr),
		.useMem(useMem), .writesAcc(writesAcc), .writesMem(writesMem)
	);

	upExecute uExecute (
		.opValid(opValid), .opcode(opcode), .operand(operand), .useMem(useMem),
		.writesAcc(writesAcc), .writesMem(writesMem), .rdData(rdData),
		.acc(acc), .carry(carry),
		.commit(commit), .nextAcc(nextAcc), .nextZero(nextZero), .nextCarry(nextCarry),
		.storeEn(storeEn), .storeData(storeData)
	);

	upResult uResult (
		.clk(clk), .nRst(nRst),
		.commit(commit), .nextAcc(nextAcc), .nextZero(nextZero), .nextCarry(nextCarry),
		.storeEn(storeEn), .storeData(storeData),
		.acc(acc), .zero(zero), .carry(carry),
		.memWe(memWe), .memWrData(memWrData)
	);

	// memAddr is still held by decode while the store pulse is out
	upMemory uMemory (
		.clk(clk), .nRst(nRst),
		.addr(memAddr), .wrData(memWrData), .we(memWe), .rdData(rdData)
	);

endmodule

//--- verilog/upDecode.sv
`timescale 1ns/1ps

module upDecode (
	input  logic                        clk,
	input  logic                        nRst,
	input  logic                        issue,
	input  upPkg::instrT                issueWord,
	output logic                        opValid,
	output upPkg::opcodeT               opcode,
	output logic [upPkg::dataWidth-1:0] operand,
	output logic [upPkg::addrWidth-1:0] memAddr,
	output logic                        useMem,
	output logic                        writesAcc,
	output logic                        writesMem
);

	import upPkg::*;

	instrT instrQ;
	logic  validQ;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			instrQ <= '0; // decodes as nop
			validQ <= 1'b0;
		end else begin
			validQ <= issue;
			if (issue) begin
				instrQ <= issueWord;
			end
		end
	end

	assign opValid = validQ;
	assign memAddr = instrQ.memView.addr; // held until the next issue

	always_comb begin
		opcode    = opNop;
		operand   = '0;
		useMem    = 1'b0;
		writesAcc = 1'b0;
		writesMem = 1'b0;
		case (instrQ.memView.opcode)
			opLdi, opAddi: begin
				opcode    = instrQ.immView.opcode;
				operand   = instrQ.immView.imm;
				writesAcc = 1'b1;
			end
			opLd, opAdd, opSub, opAnd, opOr, opXor: begin
				opcode    = instrQ.memView.opcode;
				useMem    = 1'b1;
				writesAcc = 1'b1;
			end
			opSt: begin
				opcode    = opSt;
				writesMem = 1'b1;
			end
			default: opcode = opNop; // nop and illegal codes
		endcase
	end

	accMemExclusive: assert property (@(posedge clk) disable iff (!nRst)
		!(writesAcc && writesMem));

endmodule

//--- verilog/upExecute.sv
`timescale 1ns/1ps

module upExecute (
	input  logic                        opValid,
	input  upPkg::opcodeT               opcode,
	input  logic [upPkg::dataWidth-1:0] operand,
	input  logic                        useMem,
	input  logic                        writesAcc,
	input  logic                        writesMem,
	input  logic [upPkg::dataWidth-1:0] rdData,
	input  logic [upPkg::dataWidth-1:0] acc,
	input  logic                        carry,
	output logic                        commit,
	output logic [upPkg::dataWidth-1:0] nextAcc,
	output logic                        nextZero,
	output logic                        nextCarry,
	output logic                        storeEn,
	output logic [upPkg::dataWidth-1:0] storeData
);

	import upPkg::*;

	logic [dataWidth-1:0] srcB;
	logic [dataWidth:0]   sum;
	logic [dataWidth:0]   diff;

	assign srcB = useMem ? rdData : operand; // memory or immediate
	assign sum  = {1'b0, acc} + {1'b0, srcB};
	assign diff = {1'b0, acc} - {1'b0, srcB}; // top bit is the borrow

	always_comb begin
		nextAcc   = acc;
		nextCarry = carry;
		case (opcode)
			opLdi, opLd: begin
				nextAcc = srcB; // carry kept
			end
			opAdd, opAddi: begin
				nextAcc   = sum[dataWidth-1:0];
				nextCarry = sum[dataWidth];
			end
			opSub: begin
				nextAcc   = diff[dataWidth-1:0];
				nextCarry = diff[dataWidth];
			end
			opAnd: begin
				nextAcc   = acc & srcB;
				nextCarry = 1'b0;
			end
			opOr: begin
				nextAcc   = acc | srcB;
				nextCarry = 1'b0;
			end
			opXor: begin
				nextAcc   = acc ^ srcB;
				nextCarry = 1'b0;
			end
			default: begin
				nextAcc   = acc; // nop and store leave acc alone
				nextCarry = carry;
			end
		endcase
	end

	assign nextZero = (nextAcc == '0);

	// flags only move with the accumulator, a store touches neither
	assign commit    = opValid && writesAcc;
	assign storeEn   = opValid && writesMem;
	assign storeData = acc;

endmodule

//--- verilog/upMemory.sv
`timescale 1ns/1ps

module upMemory (
	input  logic                        clk,
	input  logic                        nRst,
	input  logic [upPkg::addrWidth-1:0] addr,
	input  logic [upPkg::dataWidth-1:0] wrData,
	input  logic                        we,
	output logic [upPkg::dataWidth-1:0] rdData
);

	import upPkg::*;

	logic [dataWidth-1:0] mem [memDepth];

	assign rdData = mem[addr]; // read is combinational

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < memDepth; i++) begin
				mem[i] <= '0; // whole array cleared
			end
		end else if (we) begin
			mem[addr] <= wrData;
		end
	end

	// a store must always land on a defined location
	weAddrKnown: assert property (@(posedge clk) disable iff (!nRst)
		we |-> !$isunknown(addr));

endmodule

//--- verilog/upPkg.sv
package upPkg;

	// datapath and memory sizes, fixed by the instruction format
	localparam int dataWidth  = 8;
	localparam int addrWidth  = 8;
	localparam int instrWidth = 16;
	localparam int memDepth   = 1 << addrWidth;

	// APB register offsets
	localparam logic [3:0] regInstr = 4'h0;
	localparam logic [3:0] regAcc   = 4'h4;
	localparam logic [3:0] regFlags = 4'h8;

	// bit positions in the flags read word
	localparam int flagZero  = 0;
	localparam int flagCarry = 1;

	typedef enum logic [3:0] {
		opNop  = 4'd0,
		opLdi  = 4'd1,
		opLd   = 4'd2,
		opSt   = 4'd3,
		opAdd  = 4'd4,
		opSub  = 4'd5,
		opAnd  = 4'd6,
		opOr   = 4'd7,
		opXor  = 4'd8,
		opAddi = 4'd9
	} opcodeT; // codes 10..15 are illegal

	// memory-operand form of an instruction
	typedef struct packed {
		opcodeT                 opcode;
		logic [3:0]             rsvd;
		logic [addrWidth-1:0]   addr;
	} instrMemT;

	// immediate-operand form of an instruction
	typedef struct packed {
		opcodeT                 opcode;
		logic [3:0]             rsvd;
		logic [dataWidth-1:0]   imm;
	} instrImmT;

	// low byte is an address or an immediate depending on the opcode
	typedef union packed {
		instrMemT memView;
		instrImmT immView;
	} instrT;

endpackage

//--- verilog/upResult.sv
`timescale 1ns/1ps

module upResult (
	input  logic                        clk,
	input  logic                        nRst,
	input  logic                        commit,
	input  logic [upPkg::dataWidth-1:0] nextAcc,
	input  logic                        nextZero,
	input  logic                        nextCarry,
	input  logic                        storeEn,
	input  logic [upPkg::dataWidth-1:0] storeData,
	output logic [upPkg::dataWidth-1:0] acc,
	output logic                        zero,
	output logic                        carry,
	output logic                        memWe,
	output logic [upPkg::dataWidth-1:0] memWrData
);

	import upPkg::*;

	logic [dataWidth-1:0] accQ;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			accQ  <= '0;
			zero  <= 1'b0;
			carry <= 1'b0;
			memWe <= 1'b0;
		end else begin
			memWe <= storeEn; // one pulse per store
			if (commit) begin
				accQ  <= nextAcc;
				zero  <= nextZero;
				carry <= nextCarry;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (storeEn) begin
			memWrData <= storeData;
		end
	end

	assign acc = accQ;

endmodule
